//--- dl_macros.svh
`ifndef DL_MACROS_SVH
`define DL_MACROS_SVH

// Download index values
// A cartridge is any index whose low six bits are at most DL_IDX_CART_MAX
`define DL_IDX_CART_MAX   6'h01
`define DL_IDX_CD_DATA    6'h02
`define DL_IDX_CD_AUDIO   6'h03
`define DL_IDX_CODE       8'hFF

// Field widths of the download stream and ROM port
`define DL_INDEX_W        8
`define DL_STREAM_AW      25
`define DL_WORD_W         16
`define DL_ROM_AW         24

// Header lines searched for the signature, ROM address bits 23 to 4
`define DL_SIG_LINE_A     20'h212
`define DL_SIG_LINE_B     20'h1F2

// Signature words, expected at line offsets 6, 8, 10 and 12
`define DL_SIG_WORD0      16'h4F50
`define DL_SIG_WORD1      16'h5550
`define DL_SIG_WORD2      16'h4F4C
`define DL_SIG_WORD3      16'h5355

`endif

//--- dl_pkg.sv
`include "dl_macros.svh"

package dl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Download stream
	//////////////////////////////////////////////////////////////////////

	// One beat from the download source
	typedef struct packed {
		logic                     active;
		logic                     wr;
		logic [`DL_INDEX_W-1:0]   index;
		logic [`DL_STREAM_AW-1:0] addr;
		logic [`DL_WORD_W-1:0]    data;
	} dl_stream_t;

	// One word towards the ROM store, byte address
	typedef struct packed {
		logic [`DL_ROM_AW-1:0] addr;
		logic [`DL_WORD_W-1:0] data;
	} rom_write_t;

	//////////////////////////////////////////////////////////////////////
	// Loader results
	//////////////////////////////////////////////////////////////////////

	// Cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// One CD byte with its strobes
	typedef struct packed {
		logic       data_wr;
		logic       audio_wr;
		logic [7:0] data;
	} cd_byte_t;

endpackage

//--- rom_image_loader.sv
`timescale 1ns/10ps
`include "dl_macros.svh"

module rom_image_loader (
	input  logic               clk_sys,
	input  logic               reset,
	input  dl_pkg::dl_stream_t stream,
	input  logic               active,
	input  logic               bit_reverse,
	input  logic               rom_ack,
	output logic               stream_wait,
	output dl_pkg::rom_write_t rom_wr,
	output logic               rom_req,
	output logic [11:0]        rom_size,
	output logic [1:0]         sig_found,
	output logic               sgx
);

	logic                  active_d;
	logic                  start;
	logic                  word_wr;
	logic [`DL_ROM_AW-1:0] wr_addr;
	logic [`DL_WORD_W-1:0] data_rev;
	logic [`DL_WORD_W-1:0] word_in;
	logic [`DL_WORD_W-1:0] wr_data;
	logic                  sig_line;
	logic                  sig_bad;

	assign start   = active && !active_d;
	assign word_wr = stream.wr && active && !start;

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	// Mirror each byte in place
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			data_rev[i]     = stream.data[7 - i];
			data_rev[8 + i] = stream.data[15 - i];
		end
	end

	assign word_in = bit_reverse ? data_rev : stream.data;

	// Word is held for the store until the next strobe
	always_ff @(posedge clk_sys) begin
		if (word_wr) begin
			wr_data <= word_in;
		end
	end

	assign rom_wr   = '{addr: wr_addr, data: wr_data};
	assign rom_size = wr_addr[`DL_ROM_AW-1:12];

	//////////////////////////////////////////////////////////////////////
	// Signature check
	//////////////////////////////////////////////////////////////////////

	// Two candidate header lines, one per 8 KB bank
	assign sig_line = (wr_addr[`DL_ROM_AW-1:4] == `DL_SIG_LINE_A) ||
		(wr_addr[`DL_ROM_AW-1:4] == `DL_SIG_LINE_B);

	always_comb begin
		case (wr_addr[3:0])
			4'd6:    sig_bad = (word_in != `DL_SIG_WORD0);
			4'd8:    sig_bad = (word_in != `DL_SIG_WORD1);
			4'd10:   sig_bad = (word_in != `DL_SIG_WORD2);
			4'd12:   sig_bad = (word_in != `DL_SIG_WORD3);
			default: sig_bad = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Toggle handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d    <= 1'b0;
			stream_wait <= 1'b0;
			rom_req     <= 1'b0;
			wr_addr     <= '0;
			sig_found   <= 2'b11;
			sgx         <= 1'b0;
		end else begin
			active_d <= active;
			if (start) begin
				// New image, odd index marks a SuperGrafx cartridge
				wr_addr   <= '0;
				sig_found <= 2'b11;
				sgx       <= stream.index[0];
			end else if (word_wr) begin
				stream_wait <= 1'b1;
				rom_req     <= ~rom_req;
				if (sig_line && sig_bad) begin
					sig_found[wr_addr[13]] <= 1'b0;
				end
			end else if (stream_wait && (rom_ack == rom_req)) begin
				// Store caught up, release the source
				stream_wait <= 1'b0;
				wr_addr     <= wr_addr + `DL_ROM_AW'd2;
			end
		end
	end

endmodule

//--- cheat_code_loader.sv
`timescale 1ns/10ps

module cheat_code_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  dl_pkg::dl_stream_t  stream,
	input  logic                active,
	output dl_pkg::cheat_code_t code,
	output logic                code_valid
);

	logic word_wr;

	assign word_wr = stream.wr && active;

	// Last word of a record sits at offset 14
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= word_wr && (stream.addr[3:0] == 4'd14);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Field assembly
	//////////////////////////////////////////////////////////////////////

	// Bottom word first, then top word, for each field
	always_ff @(posedge clk_sys) begin
		if (word_wr) begin
			case (stream.addr[3:0])
				4'd0:  code.flags[15:0]    <= stream.data;
				4'd2:  code.flags[31:16]   <= stream.data;
				4'd4:  code.addr[15:0]     <= stream.data;
				4'd6:  code.addr[31:16]    <= stream.data;
				4'd8:  code.compare[15:0]  <= stream.data;
				4'd10: code.compare[31:16] <= stream.data;
				4'd12: code.replace[15:0]  <= stream.data;
				4'd14: code.replace[31:16] <= stream.data;
				default: begin
				end
			endcase
		end
	end

endmodule

//--- cd_sector_unpacker.sv
`timescale 1ns/10ps

module cd_sector_unpacker (
	input  logic               clk_sys,
	input  logic               reset,
	input  dl_pkg::dl_stream_t stream,
	input  logic               data_active,
	input  logic               audio_active,
	output dl_pkg::cd_byte_t   cd_out,
	output logic               cd_mode
);

	logic        any_active;
	logic        active_d;
	logic        start;
	logic        head_pos;
	logic [14:0] byte_len;
	logic [14:0] byte_cnt;
	logic        word_pending;
	logic        phase;
	logic        byte_sel;
	logic        data_stb;
	logic        audio_stb;
	logic [15:0] word_q;

	assign any_active = data_active || audio_active;
	assign start      = any_active && !active_d;

	// Low byte first, selector flips after each strobe
	assign cd_out = '{
		data_wr:  data_stb,
		audio_wr: audio_stb,
		data:     byte_sel ? word_q[15:8] : word_q[7:0]
	};

	//////////////////////////////////////////////////////////////////////
	// Header and byte sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || start) begin
			active_d     <= any_active && !reset;
			head_pos     <= 1'b0;
			byte_len     <= '0;
			byte_cnt     <= '0;
			cd_mode      <= 1'b0;
			word_pending <= 1'b0;
			phase        <= 1'b0;
			byte_sel     <= 1'b0;
			data_stb     <= 1'b0;
			audio_stb    <= 1'b0;
		end else begin
			active_d <= any_active;

			// One strobe cycle, then one idle cycle per byte
			if (word_pending) begin
				if (!phase) begin
					phase     <= 1'b1;
					data_stb  <= data_active;
					audio_stb <= audio_active;
				end else begin
					phase     <= 1'b0;
					data_stb  <= 1'b0;
					audio_stb <= 1'b0;
					byte_sel  <= ~byte_sel;
					byte_cnt  <= byte_cnt + 15'd1;
					// Pair ends early on the last byte of the sector
					if (byte_sel || (byte_cnt >= byte_len - 15'd1)) begin
						word_pending <= 1'b0;
					end
				end
			end

			if (stream.wr && any_active) begin
				if (!head_pos) begin
					{cd_mode, byte_len} <= stream.data;
					byte_cnt <= '0;
					head_pos <= 1'b1;
				end else if (byte_cnt < byte_len) begin
					word_pending <= 1'b1;
					byte_sel     <= 1'b0;
					word_q       <= stream.data;
				end
			end
		end
	end

endmodule

//--- download_router.sv
`timescale 1ns/10ps
`include "dl_macros.svh"

module download_router (
	input  logic                clk_sys,
	input  logic                reset,
	input  dl_pkg::dl_stream_t  stream,
	input  logic                rom_bit_reverse,
	output logic                stream_wait,
	output dl_pkg::rom_write_t  rom_wr,
	output logic                rom_req,
	input  logic                rom_ack,
	output logic [11:0]         rom_size,
	output logic [1:0]          sig_found,
	output logic                sgx,
	output dl_pkg::cheat_code_t code,
	output logic                code_valid,
	output dl_pkg::cd_byte_t    cd_out,
	output logic                cd_mode
);

	logic cart_active;
	logic code_active;
	logic cd_data_active;
	logic cd_audio_active;

	//////////////////////////////////////////////////////////////////////
	// Index decode
	//////////////////////////////////////////////////////////////////////

	assign cart_active     = stream.active && (stream.index[5:0] <= `DL_IDX_CART_MAX);
	assign code_active     = stream.active && (stream.index == `DL_IDX_CODE);
	assign cd_data_active  = stream.active && (stream.index[5:0] == `DL_IDX_CD_DATA);
	assign cd_audio_active = stream.active && (stream.index[5:0] == `DL_IDX_CD_AUDIO);

	//////////////////////////////////////////////////////////////////////
	// Loaders
	//////////////////////////////////////////////////////////////////////

	rom_image_loader u_rom_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stream      (stream),
		.active      (cart_active),
		.bit_reverse (rom_bit_reverse),
		.rom_ack     (rom_ack),
		.stream_wait (stream_wait),
		.rom_wr      (rom_wr),
		.rom_req     (rom_req),
		.rom_size    (rom_size),
		.sig_found   (sig_found),
		.sgx         (sgx)
	);

	cheat_code_loader u_code_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.stream     (stream),
		.active     (code_active),
		.code       (code),
		.code_valid (code_valid)
	);

	cd_sector_unpacker u_cd_unpacker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.stream       (stream),
		.data_active  (cd_data_active),
		.audio_active (cd_audio_active),
		.cd_out       (cd_out),
		.cd_mode      (cd_mode)
	);

endmodule

//--- download_router_chk.sv
`timescale 1ns/10ps

module download_router_chk (
	input logic             clk_sys,
	input logic             reset,
	input logic             stream_wait,
	input logic             rom_req,
	input logic             code_valid,
	input dl_pkg::cd_byte_t cd_out
);

	// Read by the testbench at the end of the run
	int unsigned assert_fails = 0;

	// Store request only toggles while the source is held off
	req_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(rom_req) |-> stream_wait)
	else begin
		assert_fails++;
		$error("rom_req changed while stream_wait was low");
	end

	// One CD sink at a time
	cd_strobes_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(cd_out.data_wr && cd_out.audio_wr))
	else begin
		assert_fails++;
		$error("CD data and audio strobes were high together");
	end

	code_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid)
	else begin
		assert_fails++;
		$error("code_valid stayed high for two cycles");
	end

endmodule

bind download_router download_router_chk u_chk (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.stream_wait (stream_wait),
	.rom_req     (rom_req),
	.code_valid  (code_valid),
	.cd_out      (cd_out)
);

//--- tb_download_router.sv
`timescale 1ns/10ps
`include "dl_macros.svh"

module tb_download_router;

	localparam int          WAIT_LIMIT = 32;
	localparam logic [15:0] CD_HEADER  = 16'h8005;

	logic                clk_sys;
	logic                reset;
	dl_pkg::dl_stream_t  stream;
	logic                rom_bit_reverse;
	logic                stream_wait;
	dl_pkg::rom_write_t  rom_wr;
	logic                rom_req;
	logic                rom_ack;
	logic [11:0]         rom_size;
	logic [1:0]          sig_found;
	logic                sgx;
	dl_pkg::cheat_code_t code;
	logic                code_valid;
	dl_pkg::cd_byte_t    cd_out;
	logic                cd_mode;

	logic [31:0] lfsr_state = 32'h7bbfcae6;
	logic [15:0] src_words [$];
	logic [15:0] rom_mem [int unsigned];
	int unsigned rom_writes = 0;
	int unsigned code_pulses = 0;
	logic [7:0]  cd_data_bytes [$];
	logic [7:0]  cd_audio_bytes [$];
	int          errors = 0;
	int          test_start_errors;
	int          tests_run = 0;
	int          tests_failed = 0;
	string       test_name;

	download_router dut (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < nbits; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			bits       = {bits[30:0], lfsr_state[31]};
			lfsr_state = {lfsr_state[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [15:0] byte_mirror(input logic [15:0] w);
		logic [15:0] r;
		for (int b = 0; b < 16; b++) begin
			r[b] = w[(b / 8) * 8 + 7 - (b % 8)];
		end
		return r;
	endfunction

	// Signature on line A, line B spoiled at offset 6
	function automatic logic [15:0] image_word(input int unsigned a);
		logic [31:0] rnd;
		case (a)
			{`DL_SIG_LINE_A, 4'd6}:                          return `DL_SIG_WORD0;
			{`DL_SIG_LINE_A, 4'd8}, {`DL_SIG_LINE_B, 4'd8}:   return `DL_SIG_WORD1;
			{`DL_SIG_LINE_A, 4'd10}, {`DL_SIG_LINE_B, 4'd10}: return `DL_SIG_WORD2;
			{`DL_SIG_LINE_A, 4'd12}, {`DL_SIG_LINE_B, 4'd12}: return `DL_SIG_WORD3;
			{`DL_SIG_LINE_B, 4'd6}:                          return ~`DL_SIG_WORD0;
			default: begin
				rnd = lfsr_take(16);
				return rnd[15:0];
			end
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] want);
		assert (got === want) else begin
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, want);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name         = name;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_start_errors) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	// One strobe, then idle until gap cycles have passed
	task automatic write_word(input logic [24:0] addr, input logic [15:0] data, input int gap);
		stream.addr = addr;
		stream.data = data;
		stream.wr   = 1'b1;
		next_cycle();
		stream.wr   = 1'b0;
		repeat (gap - 1) next_cycle();
	endtask

	task automatic write_cart_word(input logic [24:0] addr, input logic [15:0] data);
		int n;
		write_word(addr, data, 1);
		check_value("stream_wait", stream_wait, 1'b1);
		n = 0;
		while (stream_wait && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("Timeout: stream_wait stayed high after a ROM write");
			errors++;
		end
		check_value("stream_wait", stream_wait, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// ROM store model and output monitors
	//////////////////////////////////////////////////////////////////////

	initial begin : rom_store_model
		int unsigned delay;
		rom_ack = 1'b0;
		forever begin
			next_cycle();
			if (rom_req != rom_ack) begin
				rom_mem[int'(rom_wr.addr)] = rom_wr.data;
				rom_writes++;
				delay = lfsr_take(2);
				repeat (delay) next_cycle();
				rom_ack = rom_req;
			end
		end
	end

	always @(posedge clk_sys) begin
		if (code_valid === 1'b1) begin
			code_pulses++;
		end
		if (cd_out.data_wr === 1'b1) begin
			cd_data_bytes.push_back(cd_out.data);
		end
		if (cd_out.audio_wr === 1'b1) begin
			cd_audio_bytes.push_back(cd_out.data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_values();
		start_test("reset_values");
		check_value("stream_wait", stream_wait, 1'b0);
		check_value("code_valid", code_valid, 1'b0);
		check_value("cd_out.data_wr", cd_out.data_wr, 1'b0);
		check_value("cd_out.audio_wr", cd_out.audio_wr, 1'b0);
		check_value("rom_req", rom_req, 1'b0);
		check_value("sig_found", sig_found, 2'b11);
		finish_test();
	endtask

	task automatic run_cart_test(input string name, input logic [7:0] index,
			input logic reverse, input int nwords, input logic [1:0] sig_want);
		int unsigned a;
		start_test(name);
		src_words.delete();
		for (int i = 0; i < nwords; i++) begin
			src_words.push_back(image_word(2 * i));
		end
		rom_mem.delete();
		rom_writes      = 0;
		rom_bit_reverse = reverse;
		stream.index    = index;
		stream.active   = 1'b1;
		next_cycle();
		foreach (src_words[i]) begin
			write_cart_word(2 * i, src_words[i]);
		end
		stream.active = 1'b0;
		next_cycle();
		check_value("rom write count", rom_writes, nwords);
		foreach (src_words[i]) begin
			a = 2 * i;
			assert (rom_mem.exists(a)) else begin
				$display("No ROM write was recorded at address 0x%h", a);
				errors++;
			end
			if (rom_mem.exists(a)) begin
				check_value("rom_wr.data", rom_mem[a],
					reverse ? byte_mirror(src_words[i]) : src_words[i]);
			end
		end
		check_value("sgx", sgx, index[0]);
		check_value("sig_found", sig_found, sig_want);
		check_value("rom_size", rom_size, (2 * nwords) >> 12);
		finish_test();
	endtask

	task automatic run_code_test();
		logic [15:0]         words [8];
		int unsigned         pulses_before;
		int                  n;
		dl_pkg::cheat_code_t want;
		start_test("cheat_code");
		pulses_before = code_pulses;
		stream.index  = `DL_IDX_CODE;
		stream.active = 1'b1;
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'(lfsr_take(16));
			write_word(2 * i, words[i], 2);
		end
		n = 0;
		while (code_pulses == pulses_before && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("Timeout: code_valid never pulsed");
			errors++;
		end
		// Window for a stray second pulse
		repeat (4) next_cycle();
		want.flags   = {words[1], words[0]};
		want.addr    = {words[3], words[2]};
		want.compare = {words[5], words[4]};
		want.replace = {words[7], words[6]};
		check_value("code", code, want);
		check_value("code_valid pulses", code_pulses - pulses_before, 1);
		stream.active = 1'b0;
		next_cycle();
		finish_test();
	endtask

	task automatic run_cd_test(input string name, input logic [7:0] index);
		logic [15:0] words [3];
		logic [7:0]  want_bytes [$];
		logic        audio;
		int          n;
		start_test(name);
		audio = (index[5:0] == `DL_IDX_CD_AUDIO);
		cd_data_bytes.delete();
		cd_audio_bytes.delete();
		stream.index  = index;
		stream.active = 1'b1;
		next_cycle();
		write_word(0, CD_HEADER, 6);
		for (int i = 0; i < 3; i++) begin
			words[i] = 16'(lfsr_take(16));
			write_word(2 * i + 2, words[i], 6);
		end
		// Low byte first, stream cut at the header length
		for (int k = 0; k < CD_HEADER[14:0]; k++) begin
			want_bytes.push_back((k % 2) ? words[k / 2][15:8] : words[k / 2][7:0]);
		end
		n = 0;
		while (cd_data_bytes.size() + cd_audio_bytes.size() < want_bytes.size()
				&& n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		assert (n < WAIT_LIMIT) else begin
			$display("Timeout: too few CD bytes arrived");
			errors++;
		end
		repeat (4) next_cycle();
		check_value("cd_mode", cd_mode, CD_HEADER[15]);
		check_value("data strobe count", cd_data_bytes.size(), audio ? 0 : want_bytes.size());
		check_value("audio strobe count", cd_audio_bytes.size(), audio ? want_bytes.size() : 0);
		foreach (want_bytes[k]) begin
			if (!audio && k < cd_data_bytes.size()) begin
				check_value("cd_out.data", cd_data_bytes[k], want_bytes[k]);
			end
			if (audio && k < cd_audio_bytes.size()) begin
				check_value("cd_out.data", cd_audio_bytes[k], want_bytes[k]);
			end
		end
		stream.active = 1'b0;
		next_cycle();
		finish_test();
	endtask

	initial begin
		reset           = 1'b1;
		stream          = '0;
		rom_bit_reverse = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		check_reset_values();
		run_cart_test("cart_plain", 8'h01, 1'b0, 8, 2'b11);
		run_cart_test("cart_reverse", 8'h00, 1'b1, 8, 2'b11);
		run_cart_test("cart_signature", 8'h01, 1'b0, 'h2130 / 2, 2'b10);
		run_code_test();
		run_cd_test("cd_data", 8'h02);
		run_cd_test("cd_audio", 8'h03);

		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, dut.u_chk.assert_fails);
		if (errors == 0 && dut.u_chk.assert_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+.
dl_pkg.sv
rom_image_loader.sv
cheat_code_loader.sv
cd_sector_unpacker.sv
download_router.sv
download_router_chk.sv
tb_download_router.sv
